/* Makefile */
# Verilator build and run for the interrupt front end testbench.
# Any variable can be overridden on the command line, e.g. make JOBS=8.

VERILATOR  ?= verilator
TOP        ?= irq_subsystem_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# The simulator exits with a failing status on $fatal or a failed assertion.
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* dv/irq_subsystem_sva.sv */
/* Assertions for the interrupt adapter.
   Reset state of the request and the request, code and flag relationship. */
`timescale 1ns/10ps

module irq_subsystem_sva (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   irq_req_i,
    input irq_cfg_pkg::irq_code_t irq_code_i,
    input irq_cfg_pkg::irq_vec_t  irq_flags_i
);

    // A reset cycle always leaves the request low.
    req_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !irq_req_i)
        else $error("Request is high in the cycle after reset");

    code_zero_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        !irq_req_i |-> (irq_code_i == '0))
        else $error("Code is not zero while the request is low");

    // The request is registered from the flags of the previous cycle.
    req_rise_needs_flag: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(irq_req_i) |-> $past(|irq_flags_i))
        else $error("Request rose without any pending flag");

endmodule

/* dv/irq_subsystem_tb.sv */
/* Testbench for the interrupt front end.
   LFSR driven lines and MSI traffic, checked against a pending set model. */
`timescale 1ns/10ps

module irq_subsystem_tb;

    localparam int IRQ_NUM_POW     = 4;
    localparam int IRQ_NUM         = 2 ** IRQ_NUM_POW;
    localparam int DEBOUNCE_CYCLES = 4;
    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 16;
    localparam int QUIET_CYCLES    = DEBOUNCE_CYCLES + 12;
    localparam int NUM_PHASES      = 5;
    localparam int PHASE_CYCLES    = 600;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + NUM_PHASES * PHASE_CYCLES + 200;

    logic                   clk_i;
    logic                   rst_i;
    irq_cfg_pkg::irq_vec_t  irq_raw_i;
    logic                   msi_valid_i;
    irq_msg_pkg::msi_msg_t  msi_msg_i;
    logic                   irq_ack_i;
    logic                   irq_req_o;
    irq_cfg_pkg::irq_code_t irq_code_o;

    logic [31:0]            lfsr_q;
    irq_cfg_pkg::irq_vec_t  model_pending;
    irq_cfg_pkg::irq_vec_t  model_enable;

    irq_subsystem_top #(
        .IRQ_NUM_POW     (IRQ_NUM_POW),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_irq_subsystem_top (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .irq_raw_i   (irq_raw_i),
        .msi_valid_i (msi_valid_i),
        .msi_msg_i   (msi_msg_i),
        .irq_ack_i   (irq_ack_i),
        .irq_req_o   (irq_req_o),
        .irq_code_o  (irq_code_o)
    );

    bind irq_adapter irq_subsystem_sva i_irq_subsystem_sva (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .irq_req_i   (irq_req_o),
        .irq_code_i  (irq_code_o),
        .irq_flags_i (irq_flags)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped by the watchdog");
    end

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_code(input irq_cfg_pkg::irq_code_t actual,
                              input irq_cfg_pkg::irq_code_t expected, input string what);
        if (actual !== expected)
            stop_run($sformatf("MISMATCH at %0t: %s is %0d, expected %0d",
                               $time, what, actual, expected));
    endtask

    task automatic check_vec(input irq_cfg_pkg::irq_vec_t actual,
                             input irq_cfg_pkg::irq_vec_t expected, input string what);
        if (actual !== expected)
            stop_run($sformatf("MISMATCH at %0t: %s is %h, expected %h",
                               $time, what, actual, expected));
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            stop_run($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                               $time, what, actual, expected));
    endtask

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit.
    function automatic logic next_rand_bit();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out_bit)
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
            value = {value[30:0], next_rand_bit()};
        return value;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(rand_bits(8)) % (hi - lo + 1);
    endfunction

    function automatic irq_cfg_pkg::irq_vec_t rand_mask();
        return irq_cfg_pkg::irq_vec_t'(rand_bits(IRQ_NUM) & rand_bits(IRQ_NUM));
    endfunction

    // The lowest set bit wins, vector 0 included.
    function automatic irq_cfg_pkg::irq_code_t lowest_vector(input irq_cfg_pkg::irq_vec_t vec);
        irq_cfg_pkg::irq_code_t code;
        logic                   found;
        code  = '0;
        found = 1'b0;
        for (int i = 0; i < IRQ_NUM; i++)
        begin
            if (vec[i] && !found)
            begin
                code  = irq_cfg_pkg::irq_code_t'(i);
                found = 1'b1;
            end
        end
        return code;
    endfunction

    // Drives one random message slot and applies the MSI rules to the model.
    task automatic drive_random_msg();
        irq_msg_pkg::msi_msg_t msg;
        logic [1:0]            op_bits;
        op_bits     = 2'(rand_bits(2));
        msg.op      = irq_msg_pkg::msi_op_e'(op_bits);
        msg.code    = irq_cfg_pkg::irq_code_t'(rand_bits(IRQ_NUM_POW));
        msi_valid_i = next_rand_bit();
        msi_msg_i   = msg;
        if (msi_valid_i)
        begin
            case (msg.op)
                irq_msg_pkg::MSI_ENABLE:  model_enable[msg.code] = 1'b1;
                irq_msg_pkg::MSI_DISABLE: model_enable[msg.code] = 1'b0;
                irq_msg_pkg::MSI_RAISE:
                begin
                    if (model_enable[msg.code])
                        model_pending[msg.code] = 1'b1;
                end
                default: ;
            endcase
        end
    endtask

    task automatic wait_quiet();
        msi_valid_i = 1'b0;
        repeat (QUIET_CYCLES) @(negedge clk_i);
    endtask

    // CPU model. After each acknowledge it waits two cycles for the request to follow.
    task automatic drain_and_check(input string phase);
        irq_cfg_pkg::irq_vec_t  served;
        irq_cfg_pkg::irq_vec_t  expected;
        irq_cfg_pkg::irq_code_t code;
        int                     prev_code;
        served    = '0;
        expected  = model_pending;
        prev_code = -1;
        check_flag(irq_req_o, |model_pending, {phase, " request before drain"});
        while (irq_req_o === 1'b1)
        begin
            code = irq_code_o;
            check_code(code, lowest_vector(model_pending), {phase, " served code"});
            if (int'(code) <= prev_code)
                stop_run($sformatf("Vector %0d was served out of order in the %s phase",
                                   code, phase));
            served[code]        = 1'b1;
            model_pending[code] = 1'b0;
            prev_code           = int'(code);
            irq_ack_i = 1'b1;
            @(negedge clk_i);
            irq_ack_i = 1'b0;
            @(negedge clk_i);
        end
        check_flag(irq_req_o, 1'b0, {phase, " request after drain"});
        check_vec(served, expected, {phase, " served set"});
        check_code(irq_code_o, '0, {phase, " code after drain"});
    endtask

    initial
    begin
        irq_cfg_pkg::irq_vec_t mask;
        int                    line_timer;
        logic                  line_high;

        lfsr_q        = 32'hdc83_1d44;
        model_pending = '0;
        model_enable  = '0;
        rst_i         = 1'b1;
        irq_raw_i     = '0;
        msi_valid_i   = 1'b0;
        msi_msg_i     = '0;
        irq_ack_i     = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;

        // Reset and idle.
        repeat (50)
        begin
            @(negedge clk_i);
            check_flag(irq_req_o, 1'b0, "idle request");
            check_code(irq_code_o, '0, "idle code");
        end

        // Short glitches must be filtered out completely.
        repeat (40)
        begin
            irq_raw_i = rand_mask();
            repeat (rand_range(1, DEBOUNCE_CYCLES - 1)) @(negedge clk_i);
            irq_raw_i = '0;
            repeat (2) @(negedge clk_i);
        end
        wait_quiet();
        check_flag(irq_req_o, 1'b0, "request after glitches");

        // Held rises, each followed by a long low so the next rise is a new edge.
        repeat (6)
        begin
            mask          = rand_mask();
            irq_raw_i     = mask;
            model_pending = model_pending | mask;
            repeat (DEBOUNCE_CYCLES + 4) @(negedge clk_i);
            irq_raw_i = '0;
            repeat (DEBOUNCE_CYCLES + 4) @(negedge clk_i);
        end
        wait_quiet();
        check_flag(irq_req_o, |model_pending, "request after held rises");
        check_code(irq_code_o, lowest_vector(model_pending), "code after held rises");

        // Priority order and acknowledge.
        drain_and_check("debounce");

        // MSI filtering through the enable set.
        repeat (300)
        begin
            drive_random_msg();
            @(negedge clk_i);
        end
        wait_quiet();
        drain_and_check("msi");

        // Mixed traffic. Each line event is either held or a glitch.
        line_timer = 0;
        line_high  = 1'b0;
        repeat (400)
        begin
            if (line_timer == 0)
            begin
                if (line_high)
                begin
                    irq_raw_i  = '0;
                    line_high  = 1'b0;
                    line_timer = DEBOUNCE_CYCLES + rand_range(2, 5);
                end
                else
                begin
                    mask      = rand_mask();
                    irq_raw_i = mask;
                    line_high = 1'b1;
                    if (next_rand_bit())
                    begin
                        model_pending = model_pending | mask;
                        line_timer    = DEBOUNCE_CYCLES + rand_range(2, 5);
                    end
                    else
                    begin
                        line_timer = rand_range(0, DEBOUNCE_CYCLES - 2);
                    end
                end
            end
            else
            begin
                line_timer--;
            end
            drive_random_msg();
            @(negedge clk_i);
        end
        msi_valid_i = 1'b0;
        // Let the current line level run its full length.
        if (line_high)
            repeat (line_timer) @(negedge clk_i);
        irq_raw_i = '0;
        wait_quiet();
        drain_and_check("mixed");

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* logic/irq_adapter.sv */
/* Interrupt adapter.
   Latches line edges and MSIs as pending flags and serves the lowest vector. */
`timescale 1ns/10ps

module irq_adapter #(
    parameter int IRQ_NUM_POW = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  irq_cfg_pkg::irq_vec_t  irq_debounced_i,
    input  logic                   msi_req_i,
    input  irq_cfg_pkg::irq_code_t msi_code_i,
    input  logic                   irq_ack_i,
    output logic                   irq_req_o,
    output irq_cfg_pkg::irq_code_t irq_code_o
);

    localparam int IRQ_NUM = 2 ** IRQ_NUM_POW;

    irq_cfg_pkg::irq_vec_t  irq_buf0;
    irq_cfg_pkg::irq_vec_t  irq_buf1;
    irq_cfg_pkg::irq_vec_t  irq_posedge;
    irq_cfg_pkg::irq_vec_t  irq_flags;
    irq_cfg_pkg::irq_vec_t  irq_flags_d;
    logic                   prior_req;
    irq_cfg_pkg::irq_code_t prior_code;

    // Rising edges of the debounced lines.
    always_comb
    begin
        irq_posedge = irq_buf0 & ~irq_buf1;
    end

    // Next pending set. An MSI set is applied last so it beats an
    // acknowledge aimed at the same vector.
    always_comb
    begin
        irq_flags_d = irq_flags | irq_posedge;
        if (irq_ack_i)
            irq_flags_d[irq_code_o] = 1'b0;
        if (msi_req_i)
            irq_flags_d[msi_code_i] = 1'b1;
    end

    // Priority search. Scanning downwards leaves the lowest pending vector,
    // and vector 0 competes like any other.
    always_comb
    begin
        prior_req  = 1'b0;
        prior_code = '0;
        for (int i = IRQ_NUM - 1; i >= 0; i--)
        begin
            if (irq_flags[i])
            begin
                prior_req  = 1'b1;
                prior_code = irq_cfg_pkg::irq_code_t'(i);
            end
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            irq_buf0   <= '0;
            irq_buf1   <= '0;
            irq_flags  <= '0;
            irq_req_o  <= 1'b0;
            irq_code_o <= '0;
        end
        else
        begin
            irq_buf0   <= irq_debounced_i;
            irq_buf1   <= irq_buf0;
            irq_flags  <= irq_flags_d;
            // The request trails the flags by one cycle.
            irq_req_o  <= prior_req;
            irq_code_o <= prior_code;
        end
    end

endmodule

/* logic/irq_cfg_pkg.sv */
/* Interrupt configuration package.
   Sizing of vector numbers, vector masks and debounce counters. */
package irq_cfg_pkg;

    // Default log2 of the vector count.
    localparam int IRQ_NUM_POW = 4;

    // Number of interrupt vectors in the default build.
    localparam int IRQ_NUM = 2 ** IRQ_NUM_POW;

    // Width of the per-line debounce counter.
    localparam int DEBOUNCE_W = 8;

    // A vector number, as presented to the CPU.
    typedef logic [IRQ_NUM_POW-1:0] irq_code_t;

    // One bit per vector, used for lines, pending flags and enables.
    typedef logic [IRQ_NUM-1:0] irq_vec_t;

endpackage

/* logic/irq_debouncer.sv */
/* Interrupt line debouncer.
   Passes each raw line on only after it has been stable long enough. */
`timescale 1ns/10ps

module irq_debouncer #(
    parameter int IRQ_NUM_POW     = 4,
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  irq_cfg_pkg::irq_vec_t irq_raw_i,
    output irq_cfg_pkg::irq_vec_t irq_debounced_o
);

    localparam int IRQ_NUM = 2 ** IRQ_NUM_POW;

    typedef logic [irq_cfg_pkg::DEBOUNCE_W-1:0] cnt_t;

    // The output flips on the cycle the counter would reach this value.
    localparam cnt_t CNT_LAST = cnt_t'(DEBOUNCE_CYCLES - 1);

    irq_cfg_pkg::irq_vec_t sync0_q;
    irq_cfg_pkg::irq_vec_t sync1_q;
    irq_cfg_pkg::irq_vec_t armed_q;
    irq_cfg_pkg::irq_vec_t line_diff;
    cnt_t                  cnt_q [IRQ_NUM];

    // Two-stage synchronizer for the asynchronous raw lines.
    always_ff @(posedge clk_i)
    begin
        sync0_q <= irq_raw_i;
        sync1_q <= sync0_q;
    end

    // A line that is not armed yet is treated as if its stable level were high,
    // so it must first settle low before a rise can be passed on.
    always_comb
    begin
        line_diff = sync1_q ^ (irq_debounced_o | ~armed_q);
    end

    always_ff @(posedge clk_i)
    begin
        for (int i = 0; i < IRQ_NUM; i++)
        begin
            if (rst_i)
            begin
                cnt_q[i]           <= '0;
                irq_debounced_o[i] <= 1'b0;
                // Lines held high during reset start disarmed.
                armed_q[i]         <= ~sync1_q[i];
            end
            else if (line_diff[i])
            begin
                if (cnt_q[i] == CNT_LAST)
                begin
                    cnt_q[i] <= '0;
                    if (armed_q[i])
                        irq_debounced_o[i] <= sync1_q[i];
                    else
                        armed_q[i] <= 1'b1;
                end
                else
                begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
            else
            begin
                cnt_q[i] <= '0; // glitch ended, start over
            end
        end
    end

endmodule

/* logic/irq_msg_pkg.sv */
/* MSI message package.
   Opcodes and the message layout seen on the MSI strobe port. */
package irq_msg_pkg;

    // Message opcodes. NOP lets a sender issue a strobe without effect.
    typedef enum logic [1:0] {
        MSI_NOP     = 2'd0,
        MSI_RAISE   = 2'd1,
        MSI_ENABLE  = 2'd2,
        MSI_DISABLE = 2'd3
    } msi_op_e;

    // One message, sampled while the strobe is high.
    typedef struct packed {
        msi_op_e               op;
        irq_cfg_pkg::irq_code_t code;
    } msi_msg_t;

endpackage

/* logic/irq_subsystem_top.sv */
/* Interrupt front end top level.
   Debouncer and MSI decoder feeding the interrupt adapter. */
`timescale 1ns/10ps

module irq_subsystem_top #(
    parameter int IRQ_NUM_POW     = irq_cfg_pkg::IRQ_NUM_POW,
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  irq_cfg_pkg::irq_vec_t  irq_raw_i,
    input  logic                   msi_valid_i,
    input  irq_msg_pkg::msi_msg_t  msi_msg_i,
    input  logic                   irq_ack_i,
    output logic                   irq_req_o,
    output irq_cfg_pkg::irq_code_t irq_code_o
);

    irq_cfg_pkg::irq_vec_t  irq_debounced;
    logic                   msi_req;
    irq_cfg_pkg::irq_code_t msi_code;

    irq_debouncer #(
        .IRQ_NUM_POW     (IRQ_NUM_POW),
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_irq_debouncer (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .irq_raw_i       (irq_raw_i),
        .irq_debounced_o (irq_debounced)
    );

    msi_decoder #(
        .IRQ_NUM_POW (IRQ_NUM_POW)
    ) i_msi_decoder (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .msi_valid_i (msi_valid_i),
        .msi_msg_i   (msi_msg_i),
        .msi_req_o   (msi_req),
        .msi_code_o  (msi_code)
    );

    irq_adapter #(
        .IRQ_NUM_POW (IRQ_NUM_POW)
    ) i_irq_adapter (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .irq_debounced_i (irq_debounced),
        .msi_req_i       (msi_req),
        .msi_code_i      (msi_code),
        .irq_ack_i       (irq_ack_i),
        .irq_req_o       (irq_req_o),
        .irq_code_o      (irq_code_o)
    );

endmodule

/* logic/msi_decoder.sv */
/* MSI message decoder.
   Keeps the per-vector enable mask and forwards raises of enabled vectors. */
`timescale 1ns/10ps

module msi_decoder #(
    parameter int IRQ_NUM_POW = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   msi_valid_i,
    input  irq_msg_pkg::msi_msg_t  msi_msg_i,
    output logic                   msi_req_o,
    output irq_cfg_pkg::irq_code_t msi_code_o
);

    localparam int IRQ_NUM = 2 ** IRQ_NUM_POW;

    logic [IRQ_NUM-1:0]     enable_q;
    irq_cfg_pkg::irq_code_t msg_code;
    logic                   msg_enabled;

    always_comb
    begin
        msg_code    = msi_msg_i.code;
        msg_enabled = enable_q[msg_code];
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            enable_q   <= '0;
            msi_req_o  <= 1'b0;
            msi_code_o <= '0;
        end
        else
        begin
            // The raise strobe lasts exactly one cycle.
            msi_req_o <= 1'b0;
            if (msi_valid_i)
            begin
                case (msi_msg_i.op)
                    irq_msg_pkg::MSI_ENABLE:
                    begin
                        enable_q[msg_code] <= 1'b1;
                    end
                    irq_msg_pkg::MSI_DISABLE:
                    begin
                        enable_q[msg_code] <= 1'b0;
                    end
                    irq_msg_pkg::MSI_RAISE:
                    begin
                        // Raises of masked vectors are dropped, not remembered.
                        if (msg_enabled)
                        begin
                            msi_req_o  <= 1'b1;
                            msi_code_o <= msg_code;
                        end
                    end
                    default:
                    begin
                        msi_req_o <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

/* project.f */
logic/irq_cfg_pkg.sv
logic/irq_msg_pkg.sv
logic/irq_debouncer.sv
logic/msi_decoder.sv
logic/irq_adapter.sv
logic/irq_subsystem_top.sv
dv/irq_subsystem_sva.sv
dv/irq_subsystem_tb.sv
